//--- tb.f
verilog/game_pkg.sv
verilog/wb_map_pkg.sv
verilog/button_debounce.sv
verilog/player_ctrl.sv
verilog/obstacle_field.sv
verilog/game_ctrl.sv
verilog/wb_status.sv
verilog/dodge_top.sv
sim/dodge_sva.sv
sim/tb_dodge.sv

//--- sim/tb_dodge.sv
//============================================================
// Directed testbench for the dodge game over its status port
// Runs with DEBOUNCE_CYCLES 4 and TICK_CYCLES 64
// Row and death checks rely on the fixed LFSR seed after reset
//============================================================
`timescale 1ns/100ps

module tb_dodge;

	import game_pkg::*;
	import wb_map_pkg::*;

	localparam int DEBOUNCE_CYCLES = 4;
	localparam int TICK_CYCLES     = 64;
	localparam int CLK_PERIOD      = 20;
	localparam int TEST_TICKS      = 40;
	localparam int BUS_CYCLES      = 800;
	localparam int WATCHDOG_CYCLES = 2 * (TEST_TICKS * TICK_CYCLES + BUS_CYCLES);

	// Button masks for press
	localparam logic [4:0] BTN_START    = 5'b00001;
	localparam logic [4:0] BTN_P1_LEFT  = 5'b00010;
	localparam logic [4:0] BTN_P1_RIGHT = 5'b00100;
	localparam logic [4:0] BTN_P2_LEFT  = 5'b01000;
	localparam logic [4:0] BTN_P2_RIGHT = 5'b10000;

	logic                 clock_50;
	logic                 arst_n;
	logic                 start_btn_n;
	logic                 p1_left_n;
	logic                 p1_right_n;
	logic                 p2_left_n;
	logic                 p2_right_n;
	logic                 wb_cyc;
	logic                 wb_stb;
	logic                 wb_we;
	logic [WB_ADDR_W-1:0] wb_adr;
	logic [WB_DATA_W-1:0] wb_dat_w;
	logic [WB_DATA_W-1:0] wb_dat_r;
	logic                 wb_ack;

	int     errors;
	integer seed;
	// Ticks already run by the LFSR before the current game
	int     game_base;
	int     last_tick;
	row_t   park1;
	row_t   park2;

	dodge_top #(
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
		.TICK_CYCLES     (TICK_CYCLES)
	) i_dut (
		.clock_50    (clock_50),
		.arst_n      (arst_n),
		.start_btn_n (start_btn_n),
		.p1_left_n   (p1_left_n),
		.p1_right_n  (p1_right_n),
		.p2_left_n   (p2_left_n),
		.p2_right_n  (p2_right_n),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack)
	);

	always #(CLK_PERIOD / 2) clock_50 = ~clock_50;

	//==========================================================
	// Compare tasks
	//==========================================================
	task automatic check_state(input game_state_e act, input game_state_e exp, input string what);
		if (act !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, act, exp);
		end
	endtask

	task automatic check_row(input row_t act, input row_t exp, input string what);
		if (act !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, what, act, exp);
		end
	endtask

	task automatic check_count(input logic [7:0] act, input logic [7:0] exp, input string what);
		if (act !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, act, exp);
		end
	endtask

	//==========================================================
	// Bus and button drivers
	//==========================================================
	task automatic bus_transfer(input logic we, input logic [WB_ADDR_W-1:0] adr,
		input logic [WB_DATA_W-1:0] wdata, output logic [WB_DATA_W-1:0] rdata, output int lat);
		logic acked;
		acked = 1'b0;
		lat   = 0;
		rdata = '0;
		@(posedge clock_50);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_dat_w <= wdata;
		// Ack and read data are stable at the falling edge
		while (!acked && lat < 8) begin
			@(negedge clock_50);
			if (wb_ack) begin
				acked = 1'b1;
				rdata = wb_dat_r;
			end else begin
				lat++;
			end
		end
		if (!acked) begin
			errors++;
			$display("ERROR at %0t: no ack within 8 cycles for address %0d", $time, adr);
		end
		@(posedge clock_50);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic wb_read(input logic [WB_ADDR_W-1:0] adr, output logic [WB_DATA_W-1:0] data);
		int lat;
		bus_transfer(1'b0, adr, '0, data, lat);
		check_count(8'(lat), 8'd1, "read ack latency");
	endtask

	task automatic wb_write(input logic [WB_ADDR_W-1:0] adr, input logic [WB_DATA_W-1:0] data);
		logic [WB_DATA_W-1:0] unused;
		int                   lat;
		bus_transfer(1'b1, adr, data, unused, lat);
		check_count(8'(lat), 8'd1, "write ack latency");
	endtask

	// Hold the buttons long enough to settle and then release them
	task automatic press(input logic [4:0] btns);
		@(posedge clock_50);
		start_btn_n <= !btns[0];
		p1_left_n   <= !btns[1];
		p1_right_n  <= !btns[2];
		p2_left_n   <= !btns[3];
		p2_right_n  <= !btns[4];
		repeat (DEBOUNCE_CYCLES + 6) @(posedge clock_50);
		start_btn_n <= 1'b1;
		p1_left_n   <= 1'b1;
		p1_right_n  <= 1'b1;
		p2_left_n   <= 1'b1;
		p2_right_n  <= 1'b1;
		repeat (DEBOUNCE_CYCLES + 6) @(posedge clock_50);
	endtask

	//==========================================================
	// Field model
	//==========================================================
	function automatic logic [7:0] lfsr_after(input int n);
		logic [7:0] s;
		s = LFSR_SEED;
		for (int i = 0; i < n; i++) begin
			// Taps 8 6 5 4, feedback enters at bit 0
			s = {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
		end
		return s;
	endfunction

	// Row k at a frame was fed in at row 7 seven minus k frames earlier
	function automatic row_t model_row(input int base, input int frame, input int k);
		int         j;
		logic [7:0] s;
		j = frame - (MATRIX_SIZE - 1) + k;
		if (j < 1 || (j % 2) == 0) begin
			return '0;
		end
		s = lfsr_after(base + j);
		return row_t'(1) << s[2:0];
	endfunction

	task automatic predict_game(input int base, input row_t p1, input row_t p2,
		output int d1, output int d2, output int last, output int pts);
		logic [1:0] alive_m;
		logic [1:0] hit;
		row_t       row0;
		alive_m = 2'b11;
		d1      = 0;
		d2      = 0;
		last    = 0;
		pts     = 0;
		for (int t = 1; t <= TEST_TICKS && last == 0; t++) begin
			row0 = model_row(base, t - 1, 0);
			hit  = {|(row0 & p2), |(row0 & p1)} & alive_m;
			if (hit[0]) begin
				d1 = t;
			end
			if (hit[1]) begin
				d2 = t;
			end
			alive_m = alive_m & ~hit;
			if (row0 != '0 && alive_m != 2'b00 && pts < SCORE_MAX) begin
				pts++;
			end
			if (alive_m == 2'b00) begin
				last = t;
			end
		end
		if (last == 0) begin
			errors++;
			$display("ERROR: model sees no game over within %0d ticks", TEST_TICKS);
		end
	endtask

	// Keep a row snapshot only if no tick fell inside it
	task automatic check_field(input int base, input string what);
		logic [WB_DATA_W-1:0] fa;
		logic [WB_DATA_W-1:0] fb;
		logic [WB_DATA_W-1:0] rd;
		row_t                 snap [MATRIX_SIZE];
		logic                 done;
		int                   tries;
		done  = 1'b0;
		tries = 0;
		while (!done && tries < 4) begin
			wb_read(REG_FRAMES, fa);
			for (int k = 0; k < MATRIX_SIZE; k++) begin
				wb_read(REG_ROW0 + WB_ADDR_W'(k), rd);
				snap[k] = row_t'(rd[7:0]);
			end
			wb_read(REG_FRAMES, fb);
			if (fa == fb) begin
				done = 1'b1;
				for (int k = 0; k < MATRIX_SIZE; k++) begin
					check_row(snap[k], model_row(base, int'(fa), k),
						$sformatf("%s row %0d at frame %0d", what, k, fa));
				end
			end
			tries++;
		end
		if (!done) begin
			errors++;
			$display("ERROR at %0t: no stable field snapshot in %s", $time, what);
		end
	endtask

	//==========================================================
	// Directed tests
	//==========================================================
	task automatic reset_values();
		logic [WB_DATA_W-1:0] rd;
		wb_read(REG_STATUS, rd);
		check_state(game_state_e'(rd[1:0]), GAME_IDLE, "state after reset");
		check_count(8'(rd[3:2]), 8'd0, "alive flags after reset");
		wb_read(REG_SCORE, rd);
		check_count(rd[7:0], 8'd0, "score after reset");
		wb_read(REG_FRAMES, rd);
		check_count(rd[7:0], 8'd0, "frames after reset");
		wb_read(REG_POS, rd);
		check_row(rd[7:0], P1_HOME, "player 1 after reset");
		check_row(rd[15:8], P2_HOME, "player 2 after reset");
		check_field(0, "reset");
		// Status registers ignore writes
		wb_write(REG_SCORE, 16'($random(seed)));
		wb_write(REG_POS, 16'($random(seed)));
		wb_read(REG_SCORE, rd);
		check_count(rd[7:0], 8'd0, "score after write");
		wb_read(REG_POS, rd);
		check_row(rd[7:0], P1_HOME, "player 1 after write");
		check_row(rd[15:8], P2_HOME, "player 2 after write");
		wb_read(REG_ROW0 + WB_ADDR_W'(MATRIX_SIZE), rd);
		check_count(rd[7:0] | rd[15:8], 8'd0, "unmapped address");
	endtask

	task automatic start_and_scroll();
		logic [WB_DATA_W-1:0] rd;
		int                   guard;
		press(BTN_START);
		wb_read(REG_STATUS, rd);
		check_state(game_state_e'(rd[1:0]), GAME_PLAY, "state after start");
		check_count(8'(rd[3:2]), 8'd3, "alive flags after start");
		// Let a few frames scroll in
		rd    = '0;
		guard = 0;
		while (rd[7:0] < 8'd3 && guard < 100) begin
			wb_read(REG_FRAMES, rd);
			guard++;
		end
		if (rd[7:0] < 8'd3) begin
			errors++;
			$display("ERROR at %0t: frame count did not reach 3 during play", $time);
		end
		check_field(game_base, "play");
	endtask

	task automatic edge_moves();
		logic [WB_DATA_W-1:0] rd;
		repeat (6) press(BTN_P1_LEFT | BTN_P2_RIGHT);
		press(BTN_P1_LEFT);
		wb_read(REG_POS, rd);
		check_row(rd[7:0], 8'h80, "player 1 at left edge");
		check_row(rd[15:8], 8'h01, "player 2 at right edge");
		press(BTN_P1_LEFT | BTN_P2_RIGHT);
		wb_read(REG_POS, rd);
		check_row(rd[7:0], 8'h80, "player 1 held at edge");
		check_row(rd[15:8], 8'h01, "player 2 held at edge");
	endtask

	task automatic play_to_game_over();
		logic [WB_DATA_W-1:0] rd;
		logic [WB_DATA_W-1:0] fa;
		logic [WB_DATA_W-1:0] fb;
		logic [WB_DATA_W-1:0] st;
		int                   d1;
		int                   d2;
		int                   pts;
		int                   guard;
		logic                 seen1;
		logic                 seen2;
		logic                 over;
		// Player 2 steps off the edge into an obstacle lane
		park1 = row_t'(1) << (MATRIX_SIZE - 1);
		park2 = row_t'(1) << 1;
		press(BTN_P2_LEFT);
		wb_read(REG_POS, rd);
		check_row(rd[15:8], park2, "player 2 parked");
		wb_read(REG_FRAMES, rd);
		if (rd[7:0] > 8'd8) begin
			errors++;
			$display("ERROR at %0t: players parked after the first obstacle row", $time);
		end
		predict_game(game_base, park1, park2, d1, d2, last_tick, pts);
		seen1 = 1'b0;
		seen2 = 1'b0;
		over  = 1'b0;
		guard = 0;
		st    = '0;
		while (!over && guard < 1000) begin
			wb_read(REG_FRAMES, fa);
			wb_read(REG_STATUS, st);
			wb_read(REG_FRAMES, fb);
			if (fa == fb) begin
				if (!seen1 && !st[2]) begin
					seen1 = 1'b1;
					check_count(fa[7:0], 8'(d1), "player 1 death tick");
				end
				if (!seen2 && !st[3]) begin
					seen2 = 1'b1;
					check_count(fa[7:0], 8'(d2), "player 2 death tick");
				end
				over = (st[1:0] == GAME_OVER);
			end
			guard++;
		end
		if (!over) begin
			errors++;
			$display("ERROR at %0t: game never reached game over", $time);
		end
		check_state(game_state_e'(st[1:0]), GAME_OVER, "state at end of game");
		check_count(8'(st[3:2]), 8'd0, "alive flags at game over");
		wb_read(REG_SCORE, rd);
		check_count(rd[7:0], 8'(pts), "final score");
		wb_read(REG_FRAMES, rd);
		check_count(rd[7:0], 8'(last_tick), "final frame count");
		// Moves are locked out once the game is over
		press(BTN_P1_RIGHT | BTN_P2_LEFT);
		wb_read(REG_POS, rd);
		check_row(rd[7:0], park1, "player 1 after game over");
		check_row(rd[15:8], park2, "player 2 after game over");
	endtask

	task automatic restart_game();
		logic [WB_DATA_W-1:0] rd;
		game_base = game_base + last_tick;
		press(BTN_START);
		wb_read(REG_FRAMES, rd);
		check_count(rd[7:0], 8'd0, "frames after restart");
		wb_read(REG_STATUS, rd);
		check_state(game_state_e'(rd[1:0]), GAME_PLAY, "state after restart");
		check_count(8'(rd[3:2]), 8'd3, "alive flags after restart");
		wb_read(REG_SCORE, rd);
		check_count(rd[7:0], 8'd0, "score after restart");
		wb_read(REG_POS, rd);
		check_row(rd[7:0], P1_HOME, "player 1 after restart");
		check_row(rd[15:8], P2_HOME, "player 2 after restart");
		check_field(game_base, "restart");
	endtask

	//==========================================================
	// Main sequence and watchdog
	//==========================================================
	initial begin
		errors      = 0;
		seed        = 32'h5219_f875;
		game_base   = 0;
		last_tick   = 0;
		clock_50    = 1'b0;
		arst_n      = 1'b0;
		start_btn_n = 1'b1;
		p1_left_n   = 1'b1;
		p1_right_n  = 1'b1;
		p2_left_n   = 1'b1;
		p2_right_n  = 1'b1;
		wb_cyc      = 1'b0;
		wb_stb      = 1'b0;
		wb_we       = 1'b0;
		wb_adr      = '0;
		wb_dat_w    = '0;
		repeat (10) @(posedge clock_50);
		arst_n <= 1'b1;
		repeat (2) @(posedge clock_50);
		reset_values();
		start_and_scroll();
		edge_moves();
		play_to_game_over();
		restart_game();
		$display("Run complete, error count %0d", errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock_50);
		$display("ERROR: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Run stopped, error count %0d", errors + 1);
		$display("TEST FAIL");
		$finish;
	end

endmodule

//--- sim/dodge_sva.sv
//============================================================
// Bus and game invariants, bound into the dodge top level
// Checks are off while arst_n is low
//============================================================
`timescale 1ns/100ps

module dodge_sva (
	input logic                  clock_50,
	input logic                  arst_n,
	input logic                  wb_cyc,
	input logic                  wb_stb,
	input logic                  wb_ack,
	input game_pkg::row_t        pos1,
	input game_pkg::row_t        pos2,
	input game_pkg::game_state_e state,
	input logic [1:0]            alive
);

	import game_pkg::*;

	// Ack only answers a request seen on the edge before
	ack_after_req: assert property (@(posedge clock_50) disable iff (!arst_n)
		wb_ack |-> $past(wb_cyc && wb_stb))
		else $error("wb_ack without a request in the previous cycle");

	ack_single: assert property (@(posedge clock_50) disable iff (!arst_n)
		wb_ack |=> !wb_ack)
		else $error("wb_ack high for two cycles in a row");

	pos_onehot: assert property (@(posedge clock_50) disable iff (!arst_n)
		$onehot(pos1) && $onehot(pos2))
		else $error("player position is not one-hot");

	over_all_dead: assert property (@(posedge clock_50) disable iff (!arst_n)
		(state == GAME_OVER) |-> (alive == 2'b00))
		else $error("game over with a player still alive");

endmodule

bind dodge_top dodge_sva i_sva (
	.clock_50 (clock_50),
	.arst_n   (arst_n),
	.wb_cyc   (wb_cyc),
	.wb_stb   (wb_stb),
	.wb_ack   (wb_ack),
	.pos1     (pos1),
	.pos2     (pos2),
	.state    (state),
	.alive    (alive)
);

//--- verilog/dodge_top.sv
//============================================================
// Two-player dodge game with a Wishbone status port
// Buttons are active low and debounced inside
// DEBOUNCE_CYCLES and TICK_CYCLES count clock_50 cycles
//============================================================
`timescale 1ns/100ps

module dodge_top #(
	parameter int DEBOUNCE_CYCLES = 500000,
	parameter int TICK_CYCLES     = 10000000
) (
	input  logic                             clock_50,
	input  logic                             arst_n,
	input  logic                             start_btn_n,
	input  logic                             p1_left_n,
	input  logic                             p1_right_n,
	input  logic                             p2_left_n,
	input  logic                             p2_right_n,
	input  logic                             wb_cyc,
	input  logic                             wb_stb,
	input  logic                             wb_we,
	input  logic [wb_map_pkg::WB_ADDR_W-1:0] wb_adr,
	input  logic [wb_map_pkg::WB_DATA_W-1:0] wb_dat_w,
	output logic [wb_map_pkg::WB_DATA_W-1:0] wb_dat_r,
	output logic                             wb_ack
);

	import game_pkg::*;

	logic                         start_press;
	logic                         p1_left_press;
	logic                         p1_right_press;
	logic                         p2_left_press;
	logic                         p2_right_press;
	logic                         tick;
	logic                         field_clear;
	logic                         home;
	logic                         move_en1;
	logic                         move_en2;
	game_state_e                  state;
	logic [1:0]                   alive;
	logic [7:0]                   score;
	logic [7:0]                   frames;
	row_t                         pos1;
	row_t                         pos2;
	row_t [MATRIX_SIZE-1:0]       rows;

	//==========================================================
	// Buttons
	//==========================================================
	button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_db_start (
		.clock_50(clock_50), .arst_n(arst_n), .btn_n(start_btn_n), .press(start_press)
	);
	button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_db_p1_left (
		.clock_50(clock_50), .arst_n(arst_n), .btn_n(p1_left_n), .press(p1_left_press)
	);
	button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_db_p1_right (
		.clock_50(clock_50), .arst_n(arst_n), .btn_n(p1_right_n), .press(p1_right_press)
	);
	button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_db_p2_left (
		.clock_50(clock_50), .arst_n(arst_n), .btn_n(p2_left_n), .press(p2_left_press)
	);
	button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_db_p2_right (
		.clock_50(clock_50), .arst_n(arst_n), .btn_n(p2_right_n), .press(p2_right_press)
	);

	//==========================================================
	// Players and field
	//==========================================================
	player_ctrl #(.HOME_POS(P1_HOME)) i_player1 (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.left     (p1_left_press),
		.right    (p1_right_press),
		.move_en  (move_en1),
		.home     (home),
		.pos      (pos1)
	);

	player_ctrl #(.HOME_POS(P2_HOME)) i_player2 (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.left     (p2_left_press),
		.right    (p2_right_press),
		.move_en  (move_en2),
		.home     (home),
		.pos      (pos2)
	);

	obstacle_field i_field (
		.clock_50    (clock_50),
		.arst_n      (arst_n),
		.tick        (tick),
		.field_clear (field_clear),
		.rows        (rows)
	);

	game_ctrl #(.TICK_CYCLES(TICK_CYCLES)) i_game (
		.clock_50    (clock_50),
		.arst_n      (arst_n),
		.start       (start_press),
		.row0        (rows[0]),
		.pos1        (pos1),
		.pos2        (pos2),
		.tick        (tick),
		.field_clear (field_clear),
		.home        (home),
		.move_en1    (move_en1),
		.move_en2    (move_en2),
		.state       (state),
		.alive       (alive),
		.score       (score),
		.frames      (frames)
	);

	// Host side status port
	wb_status i_wb (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.state    (state),
		.alive    (alive),
		.score    (score),
		.frames   (frames),
		.pos1     (pos1),
		.pos2     (pos2),
		.rows     (rows)
	);

endmodule

//--- verilog/wb_status.sv
//============================================================
// Read-only Wishbone classic slave over the game status
// Ack and data are registered, one wait state per access
// Writes are acknowledged, dropped, and return zero data
//============================================================
`timescale 1ns/100ps

module wb_status (
	input  logic                                       clock_50,
	input  logic                                       arst_n,
	input  logic                                       wb_cyc,
	input  logic                                       wb_stb,
	input  logic                                       wb_we,
	input  logic [wb_map_pkg::WB_ADDR_W-1:0]           wb_adr,
	input  logic [wb_map_pkg::WB_DATA_W-1:0]           wb_dat_w,
	output logic [wb_map_pkg::WB_DATA_W-1:0]           wb_dat_r,
	output logic                                       wb_ack,
	input  game_pkg::game_state_e                      state,
	input  logic [1:0]                                 alive,
	input  logic [7:0]                                 score,
	input  logic [7:0]                                 frames,
	input  game_pkg::row_t                             pos1,
	input  game_pkg::row_t                             pos2,
	input  game_pkg::row_t [game_pkg::MATRIX_SIZE-1:0] rows
);

	import game_pkg::*;
	import wb_map_pkg::*;

	logic                 req;
	logic [WB_DATA_W-1:0] rd_data;

	// New request, the ack low keeps it to one per access
	assign req = wb_cyc && wb_stb && !wb_ack;

	// Register map decode
	always_comb begin
		rd_data = '0;
		case (wb_adr)
			REG_STATUS: rd_data = WB_DATA_W'({alive, state});
			REG_SCORE:  rd_data = WB_DATA_W'(score);
			REG_FRAMES: rd_data = WB_DATA_W'(frames);
			REG_POS:    rd_data = WB_DATA_W'({pos2, pos1});
			default: begin
				for (int k = 0; k < MATRIX_SIZE; k++) begin
					if (wb_adr == REG_ROW0 + WB_ADDR_W'(k)) begin
						rd_data = WB_DATA_W'(rows[k]);
					end
				end
			end
		endcase
	end

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= req;
		end
	end

	// wb_dat_w has no destination, all registers are status
	always_ff @(posedge clock_50) begin
		if (req) begin
			wb_dat_r <= wb_we ? '0 : rd_data;
		end
	end

endmodule

//--- verilog/game_ctrl.sv
//============================================================
// Game FSM with fixed-rate tick, collision, score and frames
// First tick comes TICK_CYCLES cycles after entering play
// Collision is judged on row 0 as it was before the shift
//============================================================
`timescale 1ns/100ps

module game_ctrl #(
	parameter int TICK_CYCLES = 10000000
) (
	input  logic                  clock_50,
	input  logic                  arst_n,
	input  logic                  start,
	input  game_pkg::row_t        row0,
	input  game_pkg::row_t        pos1,
	input  game_pkg::row_t        pos2,
	output logic                  tick,
	output logic                  field_clear,
	output logic                  home,
	output logic                  move_en1,
	output logic                  move_en2,
	output game_pkg::game_state_e state,
	output logic [1:0]            alive,
	output logic [7:0]            score,
	output logic [7:0]            frames
);

	import game_pkg::*;

	localparam int TICK_W = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;

	logic [TICK_W-1:0] tick_cnt;
	logic              playing;
	logic              launch;
	logic [1:0]        hit;
	logic [1:0]        alive_next;

	assign playing = (state == GAME_PLAY);
	// Start press from idle or game over
	assign launch  = start && !playing;
	assign tick    = playing && (tick_cnt == TICK_W'(TICK_CYCLES - 1));

	assign field_clear = launch;
	assign home        = launch;
	assign move_en1    = playing && alive[0];
	assign move_en2    = playing && alive[1];

	assign hit[0]     = |(row0 & pos1);
	assign hit[1]     = |(row0 & pos2);
	assign alive_next = alive & ~hit;

	//==========================================================
	// State machine
	//==========================================================
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			state <= GAME_IDLE;
		end else begin
			case (state)
				GAME_IDLE, GAME_OVER: begin
					if (start) begin
						state <= GAME_PLAY;
					end
				end
				GAME_PLAY: begin
					if (tick && (alive_next == 2'b00)) begin
						state <= GAME_OVER;
					end
				end
				default: begin
					state <= GAME_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			tick_cnt <= '0;
		end else if (launch || tick) begin
			tick_cnt <= '0;
		end else if (playing) begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	//==========================================================
	// Alive flags, score and frame count
	//==========================================================
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			alive  <= 2'b00;
			score  <= '0;
			frames <= '0;
		end else if (launch) begin
			alive  <= 2'b11;
			score  <= '0;
			frames <= '0;
		end else if (tick) begin
			alive  <= alive_next;
			frames <= frames + 1'b1;
			// A point for each obstacle row someone survived
			if ((row0 != '0) && (alive_next != 2'b00) && (score != 8'(SCORE_MAX))) begin
				score <= score + 1'b1;
			end
		end
	end

endmodule

//--- verilog/obstacle_field.sv
//============================================================
// Eight obstacle rows that scroll toward row 0 on each tick
// Row 7 gets a one-hot LFSR row on odd frames, a gap on even
// field_clear empties the rows but leaves the LFSR running
//============================================================
`timescale 1ns/100ps

module obstacle_field (
	input  logic                                       clock_50,
	input  logic                                       arst_n,
	input  logic                                       tick,
	input  logic                                       field_clear,
	output game_pkg::row_t [game_pkg::MATRIX_SIZE-1:0] rows
);

	import game_pkg::*;

	localparam int IDX_W = $clog2(MATRIX_SIZE);

	logic [7:0] lfsr;
	logic [7:0] lfsr_next;
	logic       frame_odd;
	row_t       new_row;

	assign lfsr_next = {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};

	// The coming frame is odd when the current one is even
	assign new_row = frame_odd ? '0 : (row_t'(1) << lfsr_next[IDX_W-1:0]);

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			lfsr <= LFSR_SEED;
		end else if (tick) begin
			lfsr <= lfsr_next;
		end
	end

	// Row k takes row k+1, row 7 takes the new row
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			rows      <= '0;
			frame_odd <= 1'b0;
		end else if (field_clear) begin
			rows      <= '0;
			frame_odd <= 1'b0;
		end else if (tick) begin
			rows      <= {new_row, rows[MATRIX_SIZE-1:1]};
			frame_odd <= ~frame_odd;
		end
	end

endmodule

//--- verilog/player_ctrl.sv
//============================================================
// One player position, one-hot, bit 7 is the left edge
// home wins over moves, left and right together hold
// Moves are taken only while move_en is high
//============================================================
`timescale 1ns/100ps

module player_ctrl #(
	parameter game_pkg::row_t HOME_POS = game_pkg::P1_HOME
) (
	input  logic           clock_50,
	input  logic           arst_n,
	input  logic           left,
	input  logic           right,
	input  logic           move_en,
	input  logic           home,
	output game_pkg::row_t pos
);

	import game_pkg::*;

	move_op_e move_op;

	//==========================================================
	// Move decode
	//==========================================================
	always_comb begin
		if (home) begin
			move_op = MOVE_HOME;
		end else if (move_en && left && !right) begin
			move_op = MOVE_LEFT;
		end else if (move_en && right && !left) begin
			move_op = MOVE_RIGHT;
		end else begin
			move_op = MOVE_HOLD;
		end
	end

	//==========================================================
	// Position register
	//==========================================================
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			pos <= HOME_POS;
		end else begin
			case (move_op)
				MOVE_HOME: begin
					pos <= HOME_POS;
				end
				MOVE_LEFT: begin
					// Stop at the left edge
					if (!pos[MATRIX_SIZE-1]) begin
						pos <= pos << 1;
					end
				end
				MOVE_RIGHT: begin
					if (!pos[0]) begin
						pos <= pos >> 1;
					end
				end
				default: begin
					pos <= pos;
				end
			endcase
		end
	end

endmodule

//--- verilog/button_debounce.sv
//============================================================
// Debounce for one active-low push button
// press pulses once, DEBOUNCE_CYCLES+2 cycles after a settled press
// Release is filtered the same way and gives no pulse
//============================================================
`timescale 1ns/100ps

module button_debounce #(
	parameter int DEBOUNCE_CYCLES = 500000
) (
	input  logic clock_50,
	input  logic arst_n,
	input  logic btn_n,
	output logic press
);

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

	logic [1:0]       sync;
	logic             level;
	logic [CNT_W-1:0] cnt;
	logic             settle;

	// Two-flop synchronizer, inverted so 1 means pressed
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			sync <= '0;
		end else begin
			sync <= {sync[0], ~btn_n};
		end
	end

	// New level has held long enough
	assign settle = (sync[1] != level) && (cnt == CNT_W'(DEBOUNCE_CYCLES - 1));

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			level <= 1'b0;
			cnt   <= '0;
			press <= 1'b0;
		end else begin
			press <= settle && sync[1];
			if (sync[1] == level) begin
				cnt <= '0;
			end else if (settle) begin
				level <= sync[1];
				cnt   <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

//--- verilog/wb_map_pkg.sv
//============================================================
// Status port map, word addresses on a 16-bit data bus
// Rows 0 to 7 occupy addresses 4 to 11
// Unmapped addresses read as zero, writes are ignored
//============================================================
package wb_map_pkg;

	parameter int WB_ADDR_W = 4;
	parameter int WB_DATA_W = 16;

	parameter logic [WB_ADDR_W-1:0] REG_STATUS = 4'd0;
	parameter logic [WB_ADDR_W-1:0] REG_SCORE  = 4'd1;
	parameter logic [WB_ADDR_W-1:0] REG_FRAMES = 4'd2;
	parameter logic [WB_ADDR_W-1:0] REG_POS    = 4'd3;
	parameter logic [WB_ADDR_W-1:0] REG_ROW0   = 4'd4;

endpackage

//--- verilog/game_pkg.sv
//============================================================
// Game-wide constants and types for the 8x8 dodge game
// The matrix is square so one size covers row width and count
// Bit 7 of a row is the leftmost column
//============================================================
package game_pkg;

	parameter int MATRIX_SIZE = 8;

	// One matrix row, also used for one-hot player positions
	typedef logic [MATRIX_SIZE-1:0] row_t;

	typedef enum logic [1:0] {
		GAME_IDLE = 2'd0,
		GAME_PLAY = 2'd1,
		GAME_OVER = 2'd2
	} game_state_e;

	typedef enum logic [1:0] {
		MOVE_HOLD  = 2'd0,
		MOVE_LEFT  = 2'd1,
		MOVE_RIGHT = 2'd2,
		MOVE_HOME  = 2'd3
	} move_op_e;

	// Start columns of the two players
	parameter row_t P1_HOME = row_t'(1) << 2;
	parameter row_t P2_HOME = row_t'(1) << 5;

	// Fibonacci LFSR with taps 8 6 5 and 4
	parameter logic [7:0] LFSR_SEED = 8'hA5;

	// Score saturates here
	parameter int SCORE_MAX = 255;

endpackage
